//--- mfp_regs_pkg.sv
package mfp_regs_pkg;

  // bus geometry
  parameter int data_width = 8;
  parameter int adr_width  = 3;

  // register map
  // timer control registers
  parameter logic [adr_width-1:0] adr_tacr = 3'd0;
  parameter logic [adr_width-1:0] adr_tbcr = 3'd1;

  // timer data (reload) registers, read returns the live counter
  parameter logic [adr_width-1:0] adr_tadr = 3'd2;
  parameter logic [adr_width-1:0] adr_tbdr = 3'd3;

  // interrupt pending, write 1 to clear
  parameter logic [adr_width-1:0] adr_ipr  = 3'd4;

  // interrupt mask, plain read/write
  parameter logic [adr_width-1:0] adr_imr  = 3'd5;

  // addresses 6 and 7 are unmapped and read as zero

  // interrupt sources
  parameter int num_irq = 2;

  // bit positions in pending and mask
  parameter int irq_bit_ta = 0;
  parameter int irq_bit_tb = 1;

endpackage

//--- mfp_timer_pkg.sv
package mfp_timer_pkg;

  // control word as seen by delay and pulse decode
  typedef struct packed {
    logic       out_reset;
    logic       mode_sel;
    logic [2:0] prescale;
  } timer_ctrl_timed_t;

  // control word as a plain 4-bit mode code
  typedef struct packed {
    logic       out_reset;
    logic [3:0] mode;
  } timer_ctrl_coded_t;

  // one 5-bit control word, two decodings
  typedef union packed {
    timer_ctrl_timed_t timed;
    timer_ctrl_coded_t coded;
  } timer_ctrl_t;

  // special mode codes
  parameter logic [3:0] mode_stopped = 4'b0000;
  parameter logic [3:0] mode_event   = 4'b1000;

  // tick divider for each prescale code
  function automatic logic [7:0] prescale_div(input logic [2:0] prescale);
    case (prescale)
      3'd1:    prescale_div = 8'd4;
      3'd2:    prescale_div = 8'd10;
      3'd3:    prescale_div = 8'd16;
      3'd4:    prescale_div = 8'd50;
      3'd5:    prescale_div = 8'd64;
      3'd6:    prescale_div = 8'd100;
      3'd7:    prescale_div = 8'd200;
      default: prescale_div = 8'd2;
    endcase
  endfunction

endpackage

//--- mfp_timer.sv
`timescale 1ns/1ps

module mfp_timer #(
  parameter int sync_stages = 2
) (
  input  logic       CLK,
  input  logic       reset,
  input  logic       xclk,
  input  logic       trig,
  input  logic       dat_we,
  input  logic       ctrl_we,
  input  logic [7:0] wdat,
  output logic [7:0] counter,
  output logic [4:0] ctrl_rd,
  output logic       tout,
  output logic       timeout
);

  mfp_timer_pkg::timer_ctrl_t ctrl_cur;
  mfp_timer_pkg::timer_ctrl_t ctrl_wr;

  logic [3:0]             mode_q;
  logic [7:0]             data_q;
  logic [7:0]             count_q;

  logic [sync_stages-1:0] trig_sync;
  logic [sync_stages-1:0] xclk_sync;
  logic                   trig_prev;
  logic                   xclk_prev;
  logic                   trig_s;
  logic                   trig_rise;
  logic                   xclk_rise;

  logic [7:0]             presc_cnt;
  logic [7:0]             presc_last;
  logic                   tick;

  logic                   running;
  logic                   event_mode;
  logic                   delay_mode;
  logic                   pulse_mode;
  logic                   count_en;

  // current word, output bit sits where out_reset is written
  assign ctrl_cur = {tout, mode_q};
  assign ctrl_wr  = wdat[4:0];
  assign ctrl_rd  = ctrl_cur;
  assign counter  = count_q;

  // synchronizers and edge detect for trigger and external clock
  always_ff @(posedge CLK) begin
    if (reset) begin
      trig_sync <= '0;
      xclk_sync <= '0;
      trig_prev <= 1'b0;
      xclk_prev <= 1'b0;
    end else begin
      trig_sync <= {trig_sync[sync_stages-2:0], trig};
      xclk_sync <= {xclk_sync[sync_stages-2:0], xclk};
      trig_prev <= trig_sync[sync_stages-1];
      xclk_prev <= xclk_sync[sync_stages-1];
    end
  end

  assign trig_s    = trig_sync[sync_stages-1];
  assign trig_rise = trig_s & ~trig_prev;
  assign xclk_rise = xclk_sync[sync_stages-1] & ~xclk_prev;

  // prescaler counts xclk edges, wraps at the divider
  assign presc_last = mfp_timer_pkg::prescale_div(ctrl_cur.timed.prescale) - 8'd1;
  assign tick       = xclk_rise && (presc_cnt >= presc_last);

  always_ff @(posedge CLK) begin
    if (reset) begin
      presc_cnt <= 8'd0;
    end else if (xclk_rise) begin
      if (tick)
        presc_cnt <= 8'd0;
      else
        presc_cnt <= presc_cnt + 8'd1;
    end
  end

  // mode decode
  assign running    = ctrl_cur.coded.mode != mfp_timer_pkg::mode_stopped;
  assign event_mode = ctrl_cur.coded.mode == mfp_timer_pkg::mode_event;
  assign delay_mode = running && !ctrl_cur.timed.mode_sel;
  assign pulse_mode = ctrl_cur.timed.mode_sel && !event_mode;

  // registered count enable, one per tick or trigger edge
  always_ff @(posedge CLK) begin
    if (reset) begin
      count_en <= 1'b0;
    end else begin
      count_en <= running && ((event_mode && trig_rise) ||
                              (delay_mode && tick) ||
                              (pulse_mode && trig_s && tick));
    end
  end

  // down-counter, reload and output toggle
  always_ff @(posedge CLK) begin
    if (reset) begin
      mode_q  <= 4'd0;
      data_q  <= 8'd0;
      count_q <= 8'd0;
      tout    <= 1'b0;
      timeout <= 1'b0;
    end else begin
      timeout <= 1'b0;

      if (dat_we)
        data_q <= wdat;

      if (!running) begin
        // counter only follows data writes while stopped
        if (dat_we)
          count_q <= wdat;
      end else if (count_en) begin
        if (count_q == 8'd1) begin
          count_q <= data_q;
          tout    <= ~tout;
          timeout <= 1'b1;
        end else begin
          count_q <= count_q - 8'd1;
        end
      end

      // clearing the output wins over a toggle in the same cycle
      if (ctrl_we) begin
        mode_q <= ctrl_wr.coded.mode;
        if (ctrl_wr.coded.out_reset)
          tout <= 1'b0;
      end
    end
  end

endmodule

//--- mfp_irq.sv
`timescale 1ns/1ps

module mfp_irq (
  input  logic                                 CLK,
  input  logic                                 reset,
  input  logic [mfp_regs_pkg::num_irq-1:0]     set,
  input  logic                                 clr_we,
  input  logic                                 mask_we,
  input  logic [mfp_regs_pkg::data_width-1:0] wdat,
  output logic [mfp_regs_pkg::data_width-1:0] pending,
  output logic [mfp_regs_pkg::data_width-1:0] mask,
  output logic                                 irq
);

  logic [mfp_regs_pkg::num_irq-1:0] pending_q;
  logic [mfp_regs_pkg::num_irq-1:0] mask_q;
  logic [mfp_regs_pkg::num_irq-1:0] clr_bits;

  // bits written as 1 are cleared
  assign clr_bits = clr_we ? wdat[mfp_regs_pkg::num_irq-1:0] : '0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pending_q <= '0;
    end else begin
      // a new timeout beats a clear of the same bit
      pending_q <= (pending_q & ~clr_bits) | set;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset)
      mask_q <= '0;
    else if (mask_we)
      mask_q <= wdat[mfp_regs_pkg::num_irq-1:0];
  end

  // readback, upper bits unused
  always_comb begin
    pending                              = '0;
    mask                                 = '0;
    pending[mfp_regs_pkg::num_irq-1:0] = pending_q;
    mask[mfp_regs_pkg::num_irq-1:0]    = mask_q;
  end

  // pending and masked in, any source
  assign irq = |(pending_q & mask_q);

endmodule

//--- mfp_bus_regs.sv
`timescale 1ns/1ps

module mfp_bus_regs (
  input  logic                                          CLK,
  input  logic                                          reset,
  input  logic                                          wb_cyc,
  input  logic                                          wb_stb,
  input  logic                                          wb_we,
  input  logic [mfp_regs_pkg::adr_width-1:0]           wb_adr,
  input  logic [mfp_regs_pkg::data_width-1:0]          wb_wdat,
  output logic [mfp_regs_pkg::data_width-1:0]          wb_rdat,
  output logic                                          wb_ack,
  output logic                                          ta_dat_we,
  output logic                                          ta_ctrl_we,
  output logic                                          tb_dat_we,
  output logic                                          tb_ctrl_we,
  output logic                                          ipr_we,
  output logic                                          imr_we,
  output logic [mfp_regs_pkg::data_width-1:0]          wdat,
  input  logic [mfp_regs_pkg::data_width-1:0]          ta_counter,
  input  logic [mfp_regs_pkg::data_width-1:0]          tb_counter,
  input  logic [$bits(mfp_timer_pkg::timer_ctrl_t)-1:0] ta_ctrl,
  input  logic [$bits(mfp_timer_pkg::timer_ctrl_t)-1:0] tb_ctrl,
  input  logic [mfp_regs_pkg::data_width-1:0]          ipr,
  input  logic [mfp_regs_pkg::data_width-1:0]          imr
);

  localparam int ctrl_width = $bits(mfp_timer_pkg::timer_ctrl_t);

  logic                                 req;
  logic                                 wr;
  logic [mfp_regs_pkg::data_width-1:0] rd_mux;

  // new request only while ack is low
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign wr  = req && wb_we;

  // one-cycle strobes, target updates on the ack edge
  assign ta_ctrl_we = wr && (wb_adr == mfp_regs_pkg::adr_tacr);
  assign tb_ctrl_we = wr && (wb_adr == mfp_regs_pkg::adr_tbcr);
  assign ta_dat_we  = wr && (wb_adr == mfp_regs_pkg::adr_tadr);
  assign tb_dat_we  = wr && (wb_adr == mfp_regs_pkg::adr_tbdr);
  assign ipr_we     = wr && (wb_adr == mfp_regs_pkg::adr_ipr);
  assign imr_we     = wr && (wb_adr == mfp_regs_pkg::adr_imr);
  assign wdat       = wb_wdat;

  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      mfp_regs_pkg::adr_tacr: rd_mux[ctrl_width-1:0] = ta_ctrl;
      mfp_regs_pkg::adr_tbcr: rd_mux[ctrl_width-1:0] = tb_ctrl;
      mfp_regs_pkg::adr_tadr: rd_mux = ta_counter;
      mfp_regs_pkg::adr_tbdr: rd_mux = tb_counter;
      mfp_regs_pkg::adr_ipr:  rd_mux = ipr;
      mfp_regs_pkg::adr_imr:  rd_mux = imr;
      default:                rd_mux = '0;
    endcase
  end

  // ack is a single-cycle pulse
  always_ff @(posedge CLK) begin
    if (reset)
      wb_ack <= 1'b0;
    else
      wb_ack <= req;
  end

  // read data captured with the request, valid with ack
  always_ff @(posedge CLK) begin
    if (req)
      wb_rdat <= rd_mux;
  end

endmodule

//--- mfp_timers.sv
`timescale 1ns/1ps

module mfp_timers #(
  parameter int sync_stages = 2
) (
  input  logic                                 CLK,
  input  logic                                 reset,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [mfp_regs_pkg::adr_width-1:0]  wb_adr,
  input  logic [mfp_regs_pkg::data_width-1:0] wb_wdat,
  output logic [mfp_regs_pkg::data_width-1:0] wb_rdat,
  output logic                                 wb_ack,
  input  logic                                 xclk,
  input  logic                                 trig_a,
  input  logic                                 trig_b,
  output logic                                 tout_a,
  output logic                                 tout_b,
  output logic                                 irq
);

  logic                                 ta_dat_we;
  logic                                 ta_ctrl_we;
  logic                                 tb_dat_we;
  logic                                 tb_ctrl_we;
  logic                                 ipr_we;
  logic                                 imr_we;
  logic [mfp_regs_pkg::data_width-1:0] wdat;
  logic [7:0]                           ta_counter;
  logic [7:0]                           tb_counter;
  logic [4:0]                           ta_ctrl;
  logic [4:0]                           tb_ctrl;
  logic                                 ta_timeout;
  logic                                 tb_timeout;
  logic [mfp_regs_pkg::num_irq-1:0]     irq_set;
  logic [mfp_regs_pkg::data_width-1:0] ipr;
  logic [mfp_regs_pkg::data_width-1:0] imr;

  // timeout pulses land on their pending bits
  assign irq_set[mfp_regs_pkg::irq_bit_ta] = ta_timeout;
  assign irq_set[mfp_regs_pkg::irq_bit_tb] = tb_timeout;

  mfp_bus_regs bus_regs (
    .CLK        (CLK),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdat    (wb_wdat),
    .wb_rdat    (wb_rdat),
    .wb_ack     (wb_ack),
    .ta_dat_we  (ta_dat_we),
    .ta_ctrl_we (ta_ctrl_we),
    .tb_dat_we  (tb_dat_we),
    .tb_ctrl_we (tb_ctrl_we),
    .ipr_we     (ipr_we),
    .imr_we     (imr_we),
    .wdat       (wdat),
    .ta_counter (ta_counter),
    .tb_counter (tb_counter),
    .ta_ctrl    (ta_ctrl),
    .tb_ctrl    (tb_ctrl),
    .ipr        (ipr),
    .imr        (imr)
  );

  mfp_timer #(.sync_stages(sync_stages)) timer_a (
    .CLK     (CLK),
    .reset   (reset),
    .xclk    (xclk),
    .trig    (trig_a),
    .dat_we  (ta_dat_we),
    .ctrl_we (ta_ctrl_we),
    .wdat    (wdat),
    .counter (ta_counter),
    .ctrl_rd (ta_ctrl),
    .tout    (tout_a),
    .timeout (ta_timeout)
  );

  mfp_timer #(.sync_stages(sync_stages)) timer_b (
    .CLK     (CLK),
    .reset   (reset),
    .xclk    (xclk),
    .trig    (trig_b),
    .dat_we  (tb_dat_we),
    .ctrl_we (tb_ctrl_we),
    .wdat    (wdat),
    .counter (tb_counter),
    .ctrl_rd (tb_ctrl),
    .tout    (tout_b),
    .timeout (tb_timeout)
  );

  mfp_irq irq_unit (
    .CLK     (CLK),
    .reset   (reset),
    .set     (irq_set),
    .clr_we  (ipr_we),
    .mask_we (imr_we),
    .wdat    (wdat),
    .pending (ipr),
    .mask    (imr),
    .irq     (irq)
  );

endmodule

//--- mfp_timers_asserts.sv
`timescale 1ns/1ps

module mfp_timers_asserts (
  input logic                                 CLK,
  input logic                                 reset,
  input logic                                 wb_cyc,
  input logic                                 wb_stb,
  input logic                                 wb_ack,
  input logic [mfp_regs_pkg::data_width-1:0] ipr,
  input logic [mfp_regs_pkg::data_width-1:0] imr,
  input logic                                 irq
);

  // ack is a single-cycle pulse
  ack_single: assert property (@(posedge CLK) disable iff (reset) wb_ack |=> !wb_ack)
    else $error("bus ack stayed high for two cycles");

  // ack only answers a live request
  ack_requested: assert property (@(posedge CLK) disable iff (reset)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("bus ack raised without an active request");

  // no enabled pending source, no request
  irq_masked: assert property (@(posedge CLK) disable iff (reset)
    ((ipr & imr) == '0) |-> !irq)
    else $error("irq high while no pending source is enabled");

endmodule

bind mfp_timers mfp_timers_asserts asserts_i (
  .CLK    (CLK),
  .reset  (reset),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .ipr    (ipr),
  .imr    (imr),
  .irq    (irq)
);

//--- tb_mfp_timers.sv
`timescale 1ns/1ps

module tb_mfp_timers;

  // step kinds
  localparam int k_write    = 0;
  localparam int k_read     = 1;
  localparam int k_trig     = 2;
  localparam int k_level    = 3;
  localparam int k_idle     = 4;
  localparam int k_wait_irq = 5;
  localparam int k_wait_cnt = 6;
  localparam int k_port     = 7;

  logic                                 CLK;
  logic                                 reset;
  logic                                 wb_cyc;
  logic                                 wb_stb;
  logic                                 wb_we;
  logic [mfp_regs_pkg::adr_width-1:0]  wb_adr;
  logic [mfp_regs_pkg::data_width-1:0] wb_wdat;
  logic [mfp_regs_pkg::data_width-1:0] wb_rdat;
  logic                                 wb_ack;
  logic                                 xclk;
  logic                                 trig_a;
  logic                                 trig_b;
  logic                                 tout_a;
  logic                                 tout_b;
  logic                                 irq;

  // stimulus table, one entry per step
  int                                   step_kind[$];
  logic [mfp_regs_pkg::adr_width-1:0]  step_adr[$];
  logic [7:0]                           step_dat[$];
  logic [7:0]                           step_exp[$];

  int errors;
  int checks;

  always #50 CLK = ~CLK;
  // external timer clock, unrelated to CLK
  always #185 xclk = ~xclk;

  mfp_timers #(.sync_stages(2)) mfp_timers_i (
    .CLK     (CLK),
    .reset   (reset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_wdat (wb_wdat),
    .wb_rdat (wb_rdat),
    .wb_ack  (wb_ack),
    .xclk    (xclk),
    .trig_a  (trig_a),
    .trig_b  (trig_b),
    .tout_a  (tout_a),
    .tout_b  (tout_b),
    .irq     (irq)
  );

  // reference model of event mode, counter starts at n
  function automatic logic [7:0] event_count(input logic [7:0] n, input logic [7:0] k);
    if (k % n == 8'd0)
      return n;
    else
      return n - (k % n);
  endfunction

  // tout parity follows the number of wraps
  function automatic logic event_tout(input logic [7:0] n, input logic [7:0] k);
    logic [7:0] wraps;
    wraps = k / n;
    return wraps[0];
  endfunction

  function automatic string step_name(input int kind);
    case (kind)
      k_write:    return "write";
      k_read:     return "read";
      k_trig:     return "trigger pulses";
      k_level:    return "trigger level";
      k_idle:     return "idle window";
      k_wait_irq: return "wait for irq";
      k_wait_cnt: return "wait for count";
      default:    return "output ports";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [7:0] got,
                             input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_step(input int kind, input logic [mfp_regs_pkg::adr_width-1:0] adr,
                          input logic [7:0] dat, input logic [7:0] exp);
    step_kind.push_back(kind);
    step_adr.push_back(adr);
    step_dat.push_back(dat);
    step_exp.push_back(exp);
  endtask

  // one Wishbone classic cycle, held until ack
  task automatic bus_cycle(input logic we, input logic [mfp_regs_pkg::adr_width-1:0] adr,
                           input logic [7:0] dat, output logic [7:0] rdat);
    int wait_cnt;
    @(negedge CLK);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    wait_cnt = 0;
    do begin
      @(negedge CLK);
      wait_cnt++;
    end while (!wb_ack && wait_cnt < 8);
    if (!wb_ack) begin
      errors++;
      $display("bus cycle to address %0d was never acknowledged", adr);
    end
    rdat   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic set_trigger(input logic [mfp_regs_pkg::adr_width-1:0] chan,
                             input logic level);
    if (chan == 3'd0)
      trig_a = level;
    else
      trig_b = level;
  endtask

  // pulses spaced at least 8 cycles, gap drawn at random
  task automatic pulse_trigger(input logic [mfp_regs_pkg::adr_width-1:0] chan,
                               input logic [7:0] count);
    logic [7:0] p;
    logic [7:0] gap;
    for (p = 8'd0; p < count; p++) begin
      gap = 8'(5 + $urandom % 4);
      @(negedge CLK);
      set_trigger(chan, 1'b1);
      repeat (3) @(negedge CLK);
      set_trigger(chan, 1'b0);
      repeat (gap) @(negedge CLK);
    end
  endtask

  task automatic wait_irq_high();
    int cyc;
    cyc = 0;
    while (!irq && cyc < 200) begin
      @(negedge CLK);
      cyc++;
    end
    if (!irq) begin
      errors++;
      $display("irq did not rise within 200 cycles");
    end
  endtask

  // poll a counter until it leaves its start value
  task automatic wait_counter_change(input logic [mfp_regs_pkg::adr_width-1:0] adr,
                                     input logic [7:0] start);
    logic [7:0] value;
    int         polls;
    polls = 0;
    value = start;
    while (value == start && polls < 100) begin
      bus_cycle(1'b0, adr, 8'd0, value);
      polls++;
    end
    if (value == start) begin
      errors++;
      $display("counter at address %0d did not change within 100 reads", adr);
    end else begin
      check_value("counter after first gated tick", value, start - 8'd1);
    end
  endtask

  task automatic build_table();
    logic [7:0] ra;
    logic [7:0] rb;
    logic [7:0] n;
    logic [7:0] k;
    logic [7:0] m;
    logic [3:0] c;
    logic       par;
    ra  = 8'($urandom);
    rb  = 8'($urandom);
    c   = 4'($urandom);
    n   = 8'(2 + $urandom % 5);
    k   = n + 8'($urandom % 8);
    m   = 8'(3 + $urandom % 200);
    par = event_tout(n, k);

    // stopped loading and control readback
    add_step(k_write, mfp_regs_pkg::adr_tadr, ra, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_tadr, 8'd0, ra);
    add_step(k_write, mfp_regs_pkg::adr_tbdr, rb, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_tbdr, 8'd0, rb);
    add_step(k_write, mfp_regs_pkg::adr_tadr, 8'd200, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_tacr, 8'h10 | {4'd0, c}, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_tacr, 8'd0, {4'd0, c});
    add_step(k_write, mfp_regs_pkg::adr_tacr, 8'h10, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_tacr, 8'd0, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_ipr, 8'hff, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_ipr, 8'd0, 8'd0);

    // event mode on timer A, at least one wrap
    add_step(k_write, mfp_regs_pkg::adr_tadr, n, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_tacr, {4'd0, mfp_timer_pkg::mode_event}, 8'd0);
    add_step(k_trig, 3'd0, k, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_tadr, 8'd0, event_count(n, k));
    add_step(k_read, mfp_regs_pkg::adr_tacr, 8'd0, {3'd0, par, mfp_timer_pkg::mode_event});
    add_step(k_port, 3'd0, 8'd0, {5'd0, 1'b0, par, 1'b0});

    // pending while masked, then enabled, then cleared
    add_step(k_read, mfp_regs_pkg::adr_ipr, 8'd0, 8'h01);
    add_step(k_write, mfp_regs_pkg::adr_imr, 8'h01, 8'd0);
    add_step(k_port, 3'd0, 8'd0, {5'd0, 1'b0, par, 1'b1});
    add_step(k_write, mfp_regs_pkg::adr_ipr, 8'h01, 8'd0);
    add_step(k_port, 3'd0, 8'd0, {5'd0, 1'b0, par, 1'b0});
    add_step(k_read, mfp_regs_pkg::adr_ipr, 8'd0, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_tacr, 8'h10, 8'd0);
    add_step(k_port, 3'd0, 8'd0, 8'd0);

    // pulse mode on timer B, prescale code 1
    add_step(k_write, mfp_regs_pkg::adr_tbdr, m, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_tbcr, 8'h09, 8'd0);
    add_step(k_idle, 3'd0, 8'd120, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_tbdr, 8'd0, m);
    add_step(k_level, 3'd1, 8'd1, 8'd0);
    add_step(k_wait_cnt, mfp_regs_pkg::adr_tbdr, 8'd0, m);
    add_step(k_level, 3'd1, 8'd0, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_tbcr, 8'h10, 8'd0);

    // delay mode on timer A, then output reset
    add_step(k_write, mfp_regs_pkg::adr_tadr, 8'd2, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_tacr, 8'h01, 8'd0);
    add_step(k_wait_irq, 3'd0, 8'd0, 8'd0);
    add_step(k_port, 3'd0, 8'd0, 8'b011);
    add_step(k_write, mfp_regs_pkg::adr_tacr, 8'h11, 8'd0);
    add_step(k_port, 3'd0, 8'd0, 8'b001);
    add_step(k_read, mfp_regs_pkg::adr_tacr, 8'd0, 8'h01);
    add_step(k_write, mfp_regs_pkg::adr_tacr, 8'h10, 8'd0);
    add_step(k_write, mfp_regs_pkg::adr_ipr, 8'hff, 8'd0);
    add_step(k_port, 3'd0, 8'd0, 8'd0);
    add_step(k_read, mfp_regs_pkg::adr_ipr, 8'd0, 8'd0);
  endtask

  initial begin
    int         i;
    int         errs_before;
    logic [7:0] rdat;
    CLK     = 1'b0;
    xclk    = 1'b0;
    reset   = 1'b1;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    trig_a  = 1'b0;
    trig_b  = 1'b0;
    errors  = 0;
    checks  = 0;
    void'($urandom(32'h1ffd));
    build_table();

    repeat (4) @(negedge CLK);
    reset = 1'b0;

    for (i = 0; i < step_kind.size(); i++) begin
      errs_before = errors;
      case (step_kind[i])
        k_write: bus_cycle(1'b1, step_adr[i], step_dat[i], rdat);
        k_read: begin
          bus_cycle(1'b0, step_adr[i], 8'd0, rdat);
          check_value($sformatf("register %0d", step_adr[i]), rdat, step_exp[i]);
        end
        k_trig: pulse_trigger(step_adr[i], step_dat[i]);
        k_level: begin
          @(negedge CLK);
          set_trigger(step_adr[i], step_dat[i][0]);
        end
        k_idle: repeat (step_dat[i]) @(negedge CLK);
        k_wait_irq: wait_irq_high();
        k_wait_cnt: wait_counter_change(step_adr[i], step_exp[i]);
        default: check_value("tout_b, tout_a, irq", {5'd0, tout_b, tout_a, irq},
                             step_exp[i]);
      endcase
      if (errors == errs_before)
        $display("step %0d %s passed", i, step_name(step_kind[i]));
      else
        $display("step %0d %s failed", i, step_name(step_kind[i]));
    end

    $display("%0d steps, %0d checks, %0d errors", step_kind.size(), checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- sources.f
mfp_regs_pkg.sv
mfp_timer_pkg.sv
mfp_timer.sv
mfp_irq.sv
mfp_bus_regs.sv
mfp_timers.sv
mfp_timers_asserts.sv
tb_mfp_timers.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mfp_timers
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

$(SIM): $(FLIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
